/* rtl/decoder_pkg.sv */
package decoder_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths

	localparam int OPCODE_W  = 8;
	localparam int STEP_W    = 2;                      // steps 0..3
	localparam int OP_KIND_W = 4;                      // ten operation kinds need four bits
	localparam int MODE_W    = 2;
	localparam int REG_SEL_W = 2;

	// step numbers, step 0 is the writeback of the finished instruction
	localparam logic [STEP_W-1:0] STEP_0 = STEP_W'(0);
	localparam logic [STEP_W-1:0] STEP_1 = STEP_W'(1);  // operand fetch
	localparam logic [STEP_W-1:0] STEP_2 = STEP_W'(2);
	localparam logic [STEP_W-1:0] STEP_3 = STEP_W'(3);  // only adc/sbc absolute gets here

	//////////////////////////////////////////////////////////////////////
	// opcodes, 6502 values

	localparam logic [OPCODE_W-1:0] ADC_IMM = 8'h69;
	localparam logic [OPCODE_W-1:0] ADC_ZPG = 8'h65;
	localparam logic [OPCODE_W-1:0] ADC_ABS = 8'h6d;
	localparam logic [OPCODE_W-1:0] SBC_IMM = 8'he9;
	localparam logic [OPCODE_W-1:0] SBC_ZPG = 8'he5;
	localparam logic [OPCODE_W-1:0] SBC_ABS = 8'hed;
	localparam logic [OPCODE_W-1:0] CMP_IMM = 8'hc9;
	localparam logic [OPCODE_W-1:0] CPX_IMM = 8'he0;
	localparam logic [OPCODE_W-1:0] CPY_IMM = 8'hc0;
	localparam logic [OPCODE_W-1:0] LDA_IMM = 8'ha9;
	localparam logic [OPCODE_W-1:0] LDX_IMM = 8'ha2;
	localparam logic [OPCODE_W-1:0] LDY_IMM = 8'ha0;
	localparam logic [OPCODE_W-1:0] SEC     = 8'h38;
	localparam logic [OPCODE_W-1:0] CLC     = 8'h18;   // differs from sec only in bit 5
	localparam logic [OPCODE_W-1:0] INX     = 8'he8;
	localparam logic [OPCODE_W-1:0] INY     = 8'hc8;
	localparam logic [OPCODE_W-1:0] DEX     = 8'hca;
	localparam logic [OPCODE_W-1:0] DEY     = 8'h88;
	localparam logic [OPCODE_W-1:0] TAX     = 8'haa;
	localparam logic [OPCODE_W-1:0] TXA     = 8'h8a;
	localparam logic [OPCODE_W-1:0] TAY     = 8'ha8;
	localparam logic [OPCODE_W-1:0] TYA     = 8'h98;
	localparam logic [OPCODE_W-1:0] JMP_ABS = 8'h4c;

	//////////////////////////////////////////////////////////////////////
	// classification codes

	localparam logic [OP_KIND_W-1:0] OP_NONE        = OP_KIND_W'(0);
	localparam logic [OP_KIND_W-1:0] OP_ADD         = OP_KIND_W'(1);
	localparam logic [OP_KIND_W-1:0] OP_SUB         = OP_KIND_W'(2);
	localparam logic [OP_KIND_W-1:0] OP_CMP         = OP_KIND_W'(3);
	localparam logic [OP_KIND_W-1:0] OP_LOAD        = OP_KIND_W'(4);
	localparam logic [OP_KIND_W-1:0] OP_XFER_TO_REG = OP_KIND_W'(5);  // tax, tay
	localparam logic [OP_KIND_W-1:0] OP_XFER_TO_AC  = OP_KIND_W'(6);  // txa, tya
	localparam logic [OP_KIND_W-1:0] OP_INCDEC      = OP_KIND_W'(7);
	localparam logic [OP_KIND_W-1:0] OP_FLAG        = OP_KIND_W'(8);
	localparam logic [OP_KIND_W-1:0] OP_JUMP        = OP_KIND_W'(9);

	localparam logic [MODE_W-1:0] MODE_IMPLIED = MODE_W'(0);
	localparam logic [MODE_W-1:0] MODE_IMM     = MODE_W'(1);
	localparam logic [MODE_W-1:0] MODE_ZPG     = MODE_W'(2);
	localparam logic [MODE_W-1:0] MODE_ABS     = MODE_W'(3);

	localparam logic [REG_SEL_W-1:0] REG_AC = REG_SEL_W'(0);
	localparam logic [REG_SEL_W-1:0] REG_X  = REG_SEL_W'(1);
	localparam logic [REG_SEL_W-1:0] REG_Y  = REG_SEL_W'(2);

	// group one fields, opcode = aaa bbb cc
	localparam logic [1:0] CC_GROUP1 = 2'b01;
	localparam logic [2:0] AAA_ADC   = 3'b011;
	localparam logic [2:0] AAA_SBC   = 3'b111;
	localparam logic [2:0] AAA_CMP   = 3'b110;
	localparam logic [2:0] AAA_LDA   = 3'b101;
	localparam logic [2:0] BBB_ZPG   = 3'b001;
	localparam logic [2:0] BBB_IMM   = 3'b010;
	localparam logic [2:0] BBB_ABS   = 3'b011;

	typedef union packed {
		logic [OPCODE_W-1:0] raw;                      // whole byte for exact matches
		struct packed {
			logic [2:0] aaa;                           // operation
			logic [2:0] bbb;                           // addressing mode
			logic [1:0] cc;                            // group
		} fld;
	} opcode_t;

endpackage

/* rtl/opcode_classifier.sv */
`timescale 1ns/1ns

module opcode_classifier (
	input  decoder_pkg::opcode_t              ir,
	output logic [decoder_pkg::OP_KIND_W-1:0] op_kind,
	output logic [decoder_pkg::MODE_W-1:0]    addr_mode,
	output logic [decoder_pkg::REG_SEL_W-1:0] reg_sel,
	output logic                              dec_sel,
	output logic [decoder_pkg::STEP_W-1:0]    last_step
);

	//////////////////////////////////////////////////////////////////////
	// operation kind and addressing mode

	always_comb begin
		op_kind   = decoder_pkg::OP_NONE;                  // unknown opcodes fall through as nops
		addr_mode = decoder_pkg::MODE_IMPLIED;
		if (ir.fld.cc == decoder_pkg::CC_GROUP1) begin
			case (ir.fld.aaa)
				decoder_pkg::AAA_ADC, decoder_pkg::AAA_SBC: begin
					op_kind = (ir.fld.aaa == decoder_pkg::AAA_ADC) ? decoder_pkg::OP_ADD :
						decoder_pkg::OP_SUB;
					case (ir.fld.bbb)
						decoder_pkg::BBB_IMM: addr_mode = decoder_pkg::MODE_IMM;
						decoder_pkg::BBB_ZPG: addr_mode = decoder_pkg::MODE_ZPG;
						decoder_pkg::BBB_ABS: addr_mode = decoder_pkg::MODE_ABS;
						default:              op_kind = decoder_pkg::OP_NONE;  // indexed modes not built
					endcase
				end
				decoder_pkg::AAA_CMP, decoder_pkg::AAA_LDA: begin
					if (ir.fld.bbb == decoder_pkg::BBB_IMM) begin  // immediate only
						op_kind = (ir.fld.aaa == decoder_pkg::AAA_CMP) ? decoder_pkg::OP_CMP :
							decoder_pkg::OP_LOAD;
						addr_mode = decoder_pkg::MODE_IMM;
					end
				end
				default: ;
			endcase
		end else begin
			case (ir.raw)                                  // everything else by exact byte
				decoder_pkg::CPX_IMM, decoder_pkg::CPY_IMM: begin
					op_kind   = decoder_pkg::OP_CMP;
					addr_mode = decoder_pkg::MODE_IMM;
				end
				decoder_pkg::LDX_IMM, decoder_pkg::LDY_IMM: begin
					op_kind   = decoder_pkg::OP_LOAD;
					addr_mode = decoder_pkg::MODE_IMM;
				end
				decoder_pkg::JMP_ABS: begin
					op_kind   = decoder_pkg::OP_JUMP;
					addr_mode = decoder_pkg::MODE_ABS;
				end
				decoder_pkg::SEC, decoder_pkg::CLC: op_kind = decoder_pkg::OP_FLAG;
				decoder_pkg::INX, decoder_pkg::INY,
				decoder_pkg::DEX, decoder_pkg::DEY: op_kind = decoder_pkg::OP_INCDEC;
				decoder_pkg::TAX, decoder_pkg::TAY: op_kind = decoder_pkg::OP_XFER_TO_REG;
				decoder_pkg::TXA, decoder_pkg::TYA: op_kind = decoder_pkg::OP_XFER_TO_AC;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register select, direction and length

	always_comb begin
		case (ir.raw)
			decoder_pkg::CPX_IMM, decoder_pkg::LDX_IMM, decoder_pkg::INX,
			decoder_pkg::DEX, decoder_pkg::TAX, decoder_pkg::TXA: reg_sel = decoder_pkg::REG_X;
			decoder_pkg::CPY_IMM, decoder_pkg::LDY_IMM, decoder_pkg::INY,
			decoder_pkg::DEY, decoder_pkg::TAY, decoder_pkg::TYA: reg_sel = decoder_pkg::REG_Y;
			default: reg_sel = decoder_pkg::REG_AC;        // adc, sbc, cmp, lda
		endcase
	end

	assign dec_sel = (ir.raw == decoder_pkg::DEX) || (ir.raw == decoder_pkg::DEY);

	always_comb begin
		case (addr_mode)
			decoder_pkg::MODE_ZPG: last_step = decoder_pkg::STEP_2;
			decoder_pkg::MODE_ABS: last_step = (op_kind == decoder_pkg::OP_JUMP) ?
				decoder_pkg::STEP_2 : decoder_pkg::STEP_3;  // jmp skips the data read
			default:               last_step = decoder_pkg::STEP_1;  // implied and immediate
		endcase
	end

endmodule

/* rtl/step_sequencer.sv */
`timescale 1ns/1ns

module step_sequencer (
	input  logic                           clk_ph2,
	input  logic                           rst,
	input  logic [decoder_pkg::STEP_W-1:0] last_step,
	output logic [decoder_pkg::STEP_W-1:0] cycle,
	output logic                           final_step,
	output logic                           i_cycle,
	output logic                           r_cycle
);

	// last step of the instruction in flight
	assign final_step = (cycle == last_step);

	//////////////////////////////////////////////////////////////////////
	// step counter and its strobes

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			cycle   <= decoder_pkg::STEP_0;
			i_cycle <= 1'b0;
			r_cycle <= 1'b0;
		end else begin
			if (final_step) begin
				cycle <= decoder_pkg::STEP_0;             // wrap into writeback of this instruction
			end else begin
				cycle <= cycle + decoder_pkg::STEP_1;
			end
			r_cycle <= final_step;                        // counter was just cleared
			i_cycle <= !final_step;                       // counter was just advanced
		end
	end

endmodule

/* rtl/address_route_decoder.sv */
`timescale 1ns/1ns

module address_route_decoder (
	input  logic                              clk_ph2,
	input  logic                              rst,
	input  logic [decoder_pkg::STEP_W-1:0]    cycle,
	input  logic                              final_step,
	input  logic [decoder_pkg::MODE_W-1:0]    addr_mode,
	input  logic [decoder_pkg::OP_KIND_W-1:0] op_kind,
	output logic                              pcl_adl,
	output logic                              pch_adh,
	output logic                              adl_abl,
	output logic                              adh_abh,
	output logic                              dl_adl,
	output logic                              dl_adh,
	output logic                              z_adh,
	output logic                              add_adl,
	output logic                              adl_pcl,
	output logic                              adh_pch,
	output logic                              pcl_pcl,
	output logic                              pch_pch,
	output logic                              i_pc
);

	logic jmp_fin;   // jump target goes onto the address bus and into pc
	logic zpg_lo;    // zero-page operand address from dl
	logic abs_hi;    // absolute operand address, low byte held in alu
	logic pc_fetch;  // plain fetch through pc
	logic one_byte;  // step 1 of a one-byte instruction, the next opcode is on the bus

	//////////////////////////////////////////////////////////////////////
	// fetch rules, first match wins

	assign jmp_fin  = final_step && (op_kind == decoder_pkg::OP_JUMP);
	assign zpg_lo   = (cycle == decoder_pkg::STEP_1) && (addr_mode == decoder_pkg::MODE_ZPG);
	assign abs_hi   = !jmp_fin && (cycle == decoder_pkg::STEP_2) &&
		(addr_mode == decoder_pkg::MODE_ABS);
	assign pc_fetch = !(jmp_fin || zpg_lo || abs_hi);
	assign one_byte = (cycle == decoder_pkg::STEP_1) &&
		(addr_mode == decoder_pkg::MODE_IMPLIED);

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			{pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh} <= '0;
			{add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc} <= '0;
		end else begin
			pcl_adl <= pc_fetch;                  // pc onto adl/adh
			pch_adh <= pc_fetch;
			adl_abl <= 1'b1;                      // every rule drives the address bus
			adh_abh <= 1'b1;
			dl_adl  <= zpg_lo;
			z_adh   <= zpg_lo;                    // page zero
			add_adl <= jmp_fin || abs_hi;         // low byte from alu hold register
			dl_adh  <= jmp_fin || abs_hi;         // high byte straight from dl
			adl_pcl <= jmp_fin;                   // load new pc
			adh_pch <= jmp_fin;
			pcl_pcl <= pc_fetch;                  // pc recirculates
			pch_pch <= pc_fetch;
			i_pc    <= (jmp_fin || pc_fetch) && !one_byte;  // zpg and abs operand reads hold pc
		end
	end

endmodule

/* rtl/datapath_route_decoder.sv */
`timescale 1ns/1ns

module datapath_route_decoder (
	input  logic                              clk_ph2,
	input  logic                              rst,
	input  logic [decoder_pkg::STEP_W-1:0]    cycle,
	input  logic                              final_step,
	input  logic [decoder_pkg::OP_KIND_W-1:0] op_kind,
	input  logic [decoder_pkg::MODE_W-1:0]    addr_mode,
	input  logic [decoder_pkg::REG_SEL_W-1:0] reg_sel,
	input  logic                              dec_sel,
	output logic                              dl_db, ac_sb, ac_db, add_sb,  // bus moves
	output logic                              sb_ac, sb_db, sb_x, sb_y,
	output logic                              x_sb, y_sb, db_sb,
	output logic                              sb_add, ndb_add, db_add,      // alu inputs
	output logic                              z_add, none_add, c_one, c_zero,
	output logic                              sums,                         // alu operation
	output logic                              avr_v, acr_c, dbz_z, db7_n, ir5_c  // flags
);

	logic wb;         // step 0, result of the finished instruction goes back
	logic addr_lo;    // absolute low byte parked in the alu
	logic fin;
	logic k_add;
	logic k_sub;
	logic k_cmp;
	logic k_load;
	logic k_to_reg;
	logic k_to_ac;
	logic k_incdec;
	logic sel_ac;
	logic sel_x;
	logic sel_y;

	//////////////////////////////////////////////////////////////////////
	// step and kind decode

	assign wb       = (cycle == decoder_pkg::STEP_0);
	assign addr_lo  = (cycle == decoder_pkg::STEP_1) && (addr_mode == decoder_pkg::MODE_ABS);
	assign fin      = final_step;                 // never high at step 0
	assign k_add    = (op_kind == decoder_pkg::OP_ADD);
	assign k_sub    = (op_kind == decoder_pkg::OP_SUB);
	assign k_cmp    = (op_kind == decoder_pkg::OP_CMP);
	assign k_load   = (op_kind == decoder_pkg::OP_LOAD);
	assign k_to_reg = (op_kind == decoder_pkg::OP_XFER_TO_REG);
	assign k_to_ac  = (op_kind == decoder_pkg::OP_XFER_TO_AC);
	assign k_incdec = (op_kind == decoder_pkg::OP_INCDEC);
	assign sel_ac   = (reg_sel == decoder_pkg::REG_AC);
	assign sel_x    = (reg_sel == decoder_pkg::REG_X);
	assign sel_y    = (reg_sel == decoder_pkg::REG_Y);

	//////////////////////////////////////////////////////////////////////
	// registered strobes for the next cycle

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			{dl_db, ac_sb, ac_db, add_sb, sb_ac, sb_db, sb_x, sb_y} <= '0;
			{x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add, none_add} <= '0;
			{c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c} <= '0;
		end else begin
			dl_db    <= addr_lo || (fin && (k_add || k_sub || k_cmp || k_load));
			ac_sb    <= fin && (k_add || k_sub || k_to_reg || (k_cmp && sel_ac));
			ac_db    <= fin && k_to_reg;
			add_sb   <= wb && (k_add || k_sub || k_incdec);  // alu result onto sb
			sb_ac    <= (wb && (k_add || k_sub)) || (fin && (k_to_ac || (k_load && sel_ac)));
			sb_db    <= (wb && (k_add || k_sub || k_incdec)) || (fin && (k_to_ac || k_incdec));
			sb_x     <= sel_x && ((wb && k_incdec) || (fin && (k_load || k_to_reg)));
			sb_y     <= sel_y && ((wb && k_incdec) || (fin && (k_load || k_to_reg)));
			x_sb     <= sel_x && fin && (k_cmp || k_to_ac || k_incdec);
			y_sb     <= sel_y && fin && (k_cmp || k_to_ac || k_incdec);
			db_sb    <= fin && k_load;
			sb_add   <= fin && (k_add || k_sub || k_cmp);
			ndb_add  <= fin && (k_sub || k_cmp);          // subtract as add of inverse
			db_add   <= addr_lo || (fin && (k_add || k_incdec));
			z_add    <= addr_lo || (fin && k_incdec && !dec_sel);  // +1 through c_one
			none_add <= fin && k_incdec && dec_sel;       // all ones plus carry
			c_one    <= fin && (k_cmp || k_incdec);
			c_zero   <= addr_lo;
			sums     <= addr_lo || (fin && (k_add || k_sub || k_cmp || k_incdec));
			avr_v    <= wb && (k_add || k_sub);
			acr_c    <= wb && (k_add || k_sub || k_cmp);
			dbz_z    <= (wb && (k_add || k_sub || k_cmp || k_incdec)) ||
				(fin && (k_load || k_to_reg || k_to_ac));
			db7_n    <= (wb && (k_add || k_sub || k_cmp || k_incdec)) ||
				(fin && (k_load || k_to_reg || k_to_ac));
			ir5_c    <= fin && (op_kind == decoder_pkg::OP_FLAG);  // carry from opcode bit 5
		end
	end

endmodule

/* rtl/instruction_decoder.sv */
`timescale 1ns/1ns

module instruction_decoder (
	input  logic                           clk_ph2,
	input  logic                           rst,
	input  decoder_pkg::opcode_t           ir,
	output logic [decoder_pkg::STEP_W-1:0] cycle,
	output logic                           i_cycle, r_cycle,
	output logic                           pcl_adl, pch_adh, adl_abl, adh_abh,  // address side
	output logic                           dl_adl, dl_adh, z_adh, add_adl,
	output logic                           adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc,
	output logic                           dl_db, ac_sb, ac_db, add_sb, sb_ac,  // data side
	output logic                           sb_db, sb_x, sb_y, x_sb, y_sb, db_sb,
	output logic                           sb_add, ndb_add, db_add, z_add, none_add,
	output logic                           c_one, c_zero, sums,
	output logic                           avr_v, acr_c, dbz_z, db7_n, ir5_c
);

	logic [decoder_pkg::OP_KIND_W-1:0] op_kind;
	logic [decoder_pkg::MODE_W-1:0]    addr_mode;
	logic [decoder_pkg::REG_SEL_W-1:0] reg_sel;
	logic                              dec_sel;
	logic [decoder_pkg::STEP_W-1:0]    last_step;
	logic                              final_step;  // shared by both route decoders

	opcode_classifier u_classifier (
		.ir, .op_kind, .addr_mode, .reg_sel, .dec_sel, .last_step
	);

	step_sequencer u_sequencer (
		.clk_ph2, .rst, .last_step, .cycle, .final_step, .i_cycle, .r_cycle
	);

	address_route_decoder u_addr_route (
		.clk_ph2, .rst, .cycle, .final_step, .addr_mode, .op_kind,
		.pcl_adl, .pch_adh, .adl_abl, .adh_abh, .dl_adl, .dl_adh, .z_adh,
		.add_adl, .adl_pcl, .adh_pch, .pcl_pcl, .pch_pch, .i_pc
	);

	datapath_route_decoder u_data_route (
		.clk_ph2, .rst, .cycle, .final_step, .op_kind, .addr_mode, .reg_sel, .dec_sel,
		.dl_db, .ac_sb, .ac_db, .add_sb, .sb_ac, .sb_db, .sb_x, .sb_y,
		.x_sb, .y_sb, .db_sb, .sb_add, .ndb_add, .db_add, .z_add, .none_add,
		.c_one, .c_zero, .sums, .avr_v, .acr_c, .dbz_z, .db7_n, .ir5_c
	);

endmodule

/* verif/decoder_checker.sv */
`timescale 1ns/1ns

module decoder_checker (
	input logic                           clk_ph2,
	input logic                           rst,
	input logic [decoder_pkg::STEP_W-1:0] cycle,
	input logic [decoder_pkg::STEP_W-1:0] last_step,
	input logic                           i_cycle,
	input logic                           r_cycle,
	input logic                           i_pc
);

	int fail_count = 0;                               // failed assertions so far

	//////////////////////////////////////////////////////////////////////
	// step sequencing

	one_phase: assert property (@(posedge clk_ph2) disable iff (!rst)
		!(i_cycle && r_cycle))                        // advance and clear are exclusive
		else begin
			fail_count++;
			$error("i_cycle and r_cycle high together");
		end

	// never past the last step of the instruction in flight, so never past 3
	step_range: assert property (@(posedge clk_ph2) disable iff (!rst)
		cycle <= last_step)
		else begin
			fail_count++;
			$error("cycle beyond the last step");
		end

	wrap_to_zero: assert property (@(posedge clk_ph2) disable iff (!rst)
		$rose(r_cycle) |-> (cycle == decoder_pkg::STEP_0))  // cleared with r_cycle
		else begin
			fail_count++;
			$error("cycle not 0 when r_cycle rose");
		end

	// pc must stay put while reset is held
	hold_pc_in_reset: assert property (@(posedge clk_ph2)
		!rst |-> !$rose(i_pc))
		else begin
			fail_count++;
			$error("i_pc rose while rst low");
		end

endmodule

/* verif/decoder_tb.sv */
`timescale 1ns/1ns

module decoder_tb;

	logic                           clk_ph2;
	logic                           rst;
	decoder_pkg::opcode_t           ir;
	logic [decoder_pkg::STEP_W-1:0] cycle;
	logic                           i_cycle, r_cycle;
	logic                           pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh;
	logic                           add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc;
	logic                           dl_db, ac_sb, ac_db, add_sb, sb_ac, sb_db, sb_x, sb_y;
	logic                           x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add, none_add;
	logic                           c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c;

	integer     seed;                                 // $random state
	int         checks;
	int         mismatches;
	int         timeouts;
	logic [7:0] ops[$];                               // opcodes still to visit

	// order of the 39-bit strobe vectors, msb first
	string strobe_names [39] = '{
		"i_cycle", "r_cycle", "pcl_adl", "pch_adh", "adl_abl", "adh_abh", "dl_adl", "dl_adh",
		"z_adh", "add_adl", "adl_pcl", "adh_pch", "pcl_pcl", "pch_pch", "i_pc", "dl_db",
		"ac_sb", "ac_db", "add_sb", "sb_ac", "sb_db", "sb_x", "sb_y", "x_sb", "y_sb", "db_sb",
		"sb_add", "ndb_add", "db_add", "z_add", "none_add", "c_one", "c_zero", "sums",
		"avr_v", "acr_c", "dbz_z", "db7_n", "ir5_c"
	};

	instruction_decoder uut (.*);

	bind instruction_decoder decoder_checker u_checker (
		.clk_ph2, .rst, .cycle, .last_step, .i_cycle, .r_cycle, .i_pc
	);

	initial begin
		clk_ph2 = 1'b0;
		forever #5 clk_ph2 = !clk_ph2;                // 10 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [38:0] expected_controls(
		input  logic [7:0]                     op,
		input  logic [decoder_pkg::STEP_W-1:0] step,
		output logic [decoder_pkg::STEP_W-1:0] next_step
	);
		logic [decoder_pkg::OP_KIND_W-1:0] kind;
		logic [decoder_pkg::MODE_W-1:0]    mode;
		logic [decoder_pkg::STEP_W-1:0]    last;
		logic on_ac, on_x, on_y, dec, fin, inc;
		logic i_cycle, r_cycle, pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh;
		logic add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc, dl_db, ac_sb, ac_db, add_sb;
		logic sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add;
		logic none_add, c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c;
		{i_cycle, r_cycle, pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh,
			add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc, dl_db, ac_sb, ac_db, add_sb,
			sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add,
			none_add, c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c, inc} = '0;
		case (op)                                     // kind by whole byte
			decoder_pkg::ADC_IMM, decoder_pkg::ADC_ZPG,
			decoder_pkg::ADC_ABS: kind = decoder_pkg::OP_ADD;
			decoder_pkg::SBC_IMM, decoder_pkg::SBC_ZPG,
			decoder_pkg::SBC_ABS: kind = decoder_pkg::OP_SUB;
			decoder_pkg::CMP_IMM, decoder_pkg::CPX_IMM,
			decoder_pkg::CPY_IMM: kind = decoder_pkg::OP_CMP;
			decoder_pkg::LDA_IMM, decoder_pkg::LDX_IMM,
			decoder_pkg::LDY_IMM: kind = decoder_pkg::OP_LOAD;
			decoder_pkg::TAX, decoder_pkg::TAY: kind = decoder_pkg::OP_XFER_TO_REG;
			decoder_pkg::TXA, decoder_pkg::TYA: kind = decoder_pkg::OP_XFER_TO_AC;
			decoder_pkg::INX, decoder_pkg::INY,
			decoder_pkg::DEX, decoder_pkg::DEY: kind = decoder_pkg::OP_INCDEC;
			decoder_pkg::SEC, decoder_pkg::CLC: kind = decoder_pkg::OP_FLAG;
			decoder_pkg::JMP_ABS: kind = decoder_pkg::OP_JUMP;
			default: kind = decoder_pkg::OP_NONE;    // runs as a one-byte nop
		endcase
		case (op)
			decoder_pkg::ADC_ZPG, decoder_pkg::SBC_ZPG: mode = decoder_pkg::MODE_ZPG;
			decoder_pkg::ADC_ABS, decoder_pkg::SBC_ABS,
			decoder_pkg::JMP_ABS: mode = decoder_pkg::MODE_ABS;
			default: begin
				if (kind == decoder_pkg::OP_ADD || kind == decoder_pkg::OP_SUB ||
					kind == decoder_pkg::OP_CMP || kind == decoder_pkg::OP_LOAD) begin
					mode = decoder_pkg::MODE_IMM;
				end else begin
					mode = decoder_pkg::MODE_IMPLIED;
				end
			end
		endcase
		on_x  = op inside {decoder_pkg::CPX_IMM, decoder_pkg::LDX_IMM, decoder_pkg::INX,
			decoder_pkg::DEX, decoder_pkg::TAX, decoder_pkg::TXA};
		on_y  = op inside {decoder_pkg::CPY_IMM, decoder_pkg::LDY_IMM, decoder_pkg::INY,
			decoder_pkg::DEY, decoder_pkg::TAY, decoder_pkg::TYA};
		on_ac = !on_x && !on_y;
		dec   = (op == decoder_pkg::DEX) || (op == decoder_pkg::DEY);
		if (mode == decoder_pkg::MODE_ZPG || kind == decoder_pkg::OP_JUMP) begin
			last = 2'd2;                              // three steps
		end else if (mode == decoder_pkg::MODE_ABS) begin
			last = 2'd3;                              // adc/sbc absolute, four steps
		end else begin
			last = 2'd1;                              // implied and immediate
		end
		fin       = (step == last);
		next_step = fin ? 2'd0 : step + 2'd1;
		r_cycle   = fin;
		i_cycle   = !fin;
		// address side, first rule that applies
		if (fin && kind == decoder_pkg::OP_JUMP) begin
			{add_adl, adl_abl, adl_pcl, dl_adh, adh_abh, adh_pch, inc} = '1;
		end else if (step == 2'd1 && mode == decoder_pkg::MODE_ZPG) begin
			{dl_adl, z_adh, adl_abl, adh_abh} = '1;
		end else if (step == 2'd2 && mode == decoder_pkg::MODE_ABS) begin
			{add_adl, dl_adh, adl_abl, adh_abh} = '1;
		end else begin
			{pcl_adl, pch_adh, adl_abl, adh_abh, pcl_pcl, pch_pch, inc} = '1;
		end
		i_pc = inc && !(step == 2'd1 && mode == decoder_pkg::MODE_IMPLIED);  // one-byte opcodes
		if (step == 2'd0) begin                       // writeback of the finished instruction
			case (kind)
				decoder_pkg::OP_ADD,
				decoder_pkg::OP_SUB: {add_sb, sb_ac, sb_db, avr_v, acr_c, dbz_z, db7_n} = '1;
				decoder_pkg::OP_CMP: {acr_c, dbz_z, db7_n} = '1;
				decoder_pkg::OP_INCDEC:
					{add_sb, sb_db, sb_x, sb_y, dbz_z, db7_n} = {2'b11, on_x, on_y, 2'b11};
				default: ;
			endcase
		end
		if (step == 2'd1 && mode == decoder_pkg::MODE_ABS) begin
			{dl_db, db_add, z_add, sums, c_zero} = '1;  // low address byte parked in alu
		end
		if (fin) begin
			case (kind)
				decoder_pkg::OP_ADD: {dl_db, db_add, ac_sb, sb_add, sums} = '1;
				decoder_pkg::OP_SUB: {dl_db, ndb_add, ac_sb, sb_add, sums} = '1;
				decoder_pkg::OP_CMP: {dl_db, ndb_add, sb_add, sums, c_one, ac_sb, x_sb, y_sb} =
					{5'b11111, on_ac, on_x, on_y};
				decoder_pkg::OP_LOAD: {dl_db, db_sb, db7_n, dbz_z, sb_ac, sb_x, sb_y} =
					{4'b1111, on_ac, on_x, on_y};
				decoder_pkg::OP_XFER_TO_REG:
					{ac_db, ac_sb, db7_n, dbz_z, sb_x, sb_y} = {4'b1111, on_x, on_y};
				decoder_pkg::OP_XFER_TO_AC:
					{sb_db, sb_ac, db7_n, dbz_z, x_sb, y_sb} = {4'b1111, on_x, on_y};
				decoder_pkg::OP_INCDEC: {sb_db, db_add, sums, c_one, x_sb, y_sb, z_add, none_add} =
					{4'b1111, on_x, on_y, !dec, dec};
				decoder_pkg::OP_FLAG: ir5_c = 1'b1;
				default: ;
			endcase
		end
		return {i_cycle, r_cycle, pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh,
			add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc, dl_db, ac_sb, ac_db, add_sb,
			sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add,
			none_add, c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// comparison

	task automatic compare_strobe(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH time %0t %s expected %b actual %b (ir %h)", $time, name, exp, act,
				ir.raw);
		end
	endtask

	task automatic verify_cycle(input logic [decoder_pkg::STEP_W-1:0] exp,
		input logic [decoder_pkg::STEP_W-1:0] act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH time %0t cycle expected %0d actual %0d", $time, exp, act);
		end
	endtask

	initial begin
		logic [7:0]                     rec_ir;
		logic [decoder_pkg::STEP_W-1:0] rec_cycle;
		logic                           rec_rst;
		logic [decoder_pkg::STEP_W-1:0] exp_cycle;
		logic [38:0]                    exp_vec;
		logic [38:0]                    act_vec;
		int                             k;
		forever begin
			@(negedge clk_ph2);
			#1;                                       // falling-edge stimulus has settled
			rec_ir    = ir.raw;
			rec_cycle = cycle;
			rec_rst   = rst;
			@(posedge clk_ph2);
			#1;
			exp_vec = expected_controls(rec_ir, rec_cycle, exp_cycle);
			if (!rec_rst) begin                       // reset clears counter and strobes
				exp_vec   = '0;
				exp_cycle = '0;
			end
			act_vec = {i_cycle, r_cycle, pcl_adl, pch_adh, adl_abl, adh_abh, dl_adl, dl_adh, z_adh,
				add_adl, adl_pcl, adh_pch, pcl_pcl, pch_pch, i_pc, dl_db, ac_sb, ac_db, add_sb,
				sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb, db_sb, sb_add, ndb_add, db_add, z_add,
				none_add, c_one, c_zero, sums, avr_v, acr_c, dbz_z, db7_n, ir5_c};
			verify_cycle(exp_cycle, cycle);
			for (k = 0; k < 39; k++) begin
				compare_strobe(strobe_names[k], exp_vec[38-k], act_vec[38-k]);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic await_fetch_step(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < 8; n++) begin                 // longest instruction is 4 steps
			@(negedge clk_ph2);
			if (cycle == decoder_pkg::STEP_1) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			timeouts++;
			$display("timeout at %0t: cycle did not come back to step 1 within 8 clocks", $time);
		end
	endtask

	initial begin
		int         i;
		int         j;
		int         k;
		int         pass;
		logic [7:0] held;
		bit         ok;
		seed   = 77;
		rst    = 1'b0;
		ir.raw = 8'hea;                               // unknown byte, runs as a nop
		ok     = 1'b1;
		ops = '{decoder_pkg::ADC_IMM, decoder_pkg::ADC_ZPG, decoder_pkg::ADC_ABS,
			decoder_pkg::SBC_IMM, decoder_pkg::SBC_ZPG, decoder_pkg::SBC_ABS, decoder_pkg::CMP_IMM,
			decoder_pkg::CPX_IMM, decoder_pkg::CPY_IMM, decoder_pkg::LDA_IMM, decoder_pkg::LDX_IMM,
			decoder_pkg::LDY_IMM, decoder_pkg::SEC, decoder_pkg::CLC, decoder_pkg::INX,
			decoder_pkg::INY, decoder_pkg::DEX, decoder_pkg::DEY, decoder_pkg::TAX, decoder_pkg::TXA,
			decoder_pkg::TAY, decoder_pkg::TYA, decoder_pkg::JMP_ABS,
			8'hea, 8'h00, 8'h75, 8'hc5, 8'h6c, 8'h7d};  // unknown, indexed, jmp indirect
		repeat (3) @(posedge clk_ph2);
		@(negedge clk_ph2);
		rst = 1'b1;
		for (pass = 0; pass < 2; pass++) begin        // two shuffles, more neighbour pairs
			for (i = ops.size() - 1; i > 0; i--) begin
				j      = {$random(seed)} % (i + 1);
				held   = ops[i];
				ops[i] = ops[j];
				ops[j] = held;
			end
			for (k = 0; k < ops.size(); k++) begin
				await_fetch_step(ok);
				if (!ok) begin
					break;
				end
				ir.raw = ops[k];                      // new opcode from step 1 on
			end
			if (!ok) begin
				break;
			end
		end
		if (ok) begin
			await_fetch_step(ok);                     // writeback of the last one
		end
		repeat (2) @(negedge clk_ph2);
		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d", checks,
			mismatches, timeouts, uut.u_checker.fail_count);
		if (mismatches == 0 && timeouts == 0 && uut.u_checker.fail_count == 0 &&
			checks > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* flist.f */
rtl/decoder_pkg.sv
rtl/opcode_classifier.sv
rtl/step_sequencer.sv
rtl/address_route_decoder.sv
rtl/datapath_route_decoder.sv
rtl/instruction_decoder.sv
verif/decoder_checker.sv
verif/decoder_tb.sv

/* Bender.yml */
package:
  name: instruction_decoder

sources:
  # rtl
  - files:
      - rtl/decoder_pkg.sv
      - rtl/opcode_classifier.sv
      - rtl/step_sequencer.sv
      - rtl/address_route_decoder.sv
      - rtl/datapath_route_decoder.sv
      - rtl/instruction_decoder.sv
  # testbench
  - target: test
    files:
      - verif/decoder_checker.sv
      - verif/decoder_tb.sv
